// File: logic/qla_axis_pkg.sv
// axis current package
// current word types, per-axis control and status structs,
// safety constants and the over-current rule

package qla_axis_pkg;

    // offset binary currents, midscale is zero amps
    localparam int               CUR_W   = 16;
    localparam logic [CUR_W-1:0] CUR_MID = 16'h8000;

    // magnitude math is done wide enough for 2*|cmd| + margin
    localparam int MAG_W = 18;

    // allowed slack on top of twice the command magnitude
    localparam logic [CUR_W-1:0] SAFETY_MARGIN = 16'h0100;

    // consecutive over-limit samples before the fault latches
    localparam int                    TRIP_CNT_W        = 4;
    localparam logic [TRIP_CNT_W-1:0] SAFETY_TRIP_COUNT = 4'd4;

    typedef logic [CUR_W-1:0] cur_t;

    // one current per axis, axis 0 in the low slice
    typedef cur_t [qla_bus_pkg::NUM_AXES-1:0] cur_vec_t;

    // command write from the decoder
    typedef struct packed {
        logic cmd_wen;
        cur_t cmd;
    } axis_ctrl_t;

    // everything readback needs from one axis
    typedef struct packed {
        cur_t                  fb;
        cur_t                  cmd;
        logic                  fault;
        logic [TRIP_CNT_W-1:0] trip_cnt;
    } axis_status_t;

    // distance from midscale
    function automatic logic [MAG_W-1:0] cur_mag(input cur_t c);
        logic [CUR_W-1:0] d;
        if (c >= CUR_MID) d = c - CUR_MID;
        else              d = CUR_MID - c;
        return {{(MAG_W-CUR_W){1'b0}}, d};
    endfunction

    // feedback too high for this command
    function automatic logic over_limit(input cur_t fb, input cur_t cmd);
        logic [MAG_W-1:0] limit;
        limit = (cur_mag(cmd) << 1) + {{(MAG_W-CUR_W){1'b0}}, SAFETY_MARGIN};
        return cur_mag(fb) > limit;
    endfunction

endpackage

// File: logic/qla_axis_safety.sv
// per-axis current safety checker
// command register, feedback latch, over-limit counter and fault latch

`timescale 1ns/1ps

module qla_axis_safety (
    input  logic                       sysclk,
    input  logic                       rst_n,
    input  qla_axis_pkg::axis_ctrl_t   ctrl,
    input  logic                       adc_valid,
    input  qla_axis_pkg::cur_t         adc_sample,
    output qla_axis_pkg::axis_status_t status
);

    import qla_axis_pkg::*;

    // latest command and feedback
    cur_t cmd_q;
    cur_t fb_q;

    // consecutive over-limit samples
    logic [TRIP_CNT_W-1:0] trip_cnt_q;
    logic                  fault_q;

    // incoming sample vs the command in force
    logic over;

    // this sample would be the one that trips
    logic last_trip;

    // ------------------------------------------------------------------------
    // command and feedback registers
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            // zero amps
            cmd_q <= CUR_MID;
        end else if (ctrl.cmd_wen) begin
            cmd_q <= ctrl.cmd;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fb_q <= CUR_MID;
        end else if (adc_valid) begin
            fb_q <= adc_sample;
        end
    end

    // ------------------------------------------------------------------------
    // safety check
    // ------------------------------------------------------------------------

    // old command is used when a sample and a write share an edge
    assign over      = over_limit(adc_sample, cmd_q);
    assign last_trip = (trip_cnt_q == SAFETY_TRIP_COUNT - 1'b1);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            trip_cnt_q <= '0;
            fault_q    <= 1'b0;
        end else if (ctrl.cmd_wen) begin
            // new command rearms the axis, wins over a same-edge sample
            trip_cnt_q <= '0;
            fault_q    <= 1'b0;
        end else if (adc_valid) begin
            if (over) begin
                // saturate at the trip count
                if (trip_cnt_q != SAFETY_TRIP_COUNT) begin
                    trip_cnt_q <= trip_cnt_q + 1'b1;
                end
                if (last_trip) begin
                    fault_q <= 1'b1;
                end
            end else begin
                // streak broken
                trip_cnt_q <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // status out
    // ------------------------------------------------------------------------

    always_comb begin
        status.fb       = fb_q;
        status.cmd      = cmd_q;
        status.fault    = fault_q;
        status.trip_cnt = trip_cnt_q;
    end

    // fault is sticky until software rewrites the command
    a_fault_sticky: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        $fell(fault_q) |-> $past(ctrl.cmd_wen)
    );

    // counter saturates
    a_cnt_max: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        trip_cnt_q <= SAFETY_TRIP_COUNT
    );

endmodule

// File: logic/qla_axis_top.sv
// current safety subsystem top
// bus decoder, four axis safety checkers, readback block

`timescale 1ns/1ps

module qla_axis_top (
    input  logic                               sysclk,
    input  logic                               rst_n,
    input  logic [qla_bus_pkg::ADDR_W-1:0]     reg_addr,
    input  logic [qla_bus_pkg::DATA_W-1:0]     reg_wdata,
    input  logic                               reg_wen,
    input  logic                               adc_valid,
    input  qla_axis_pkg::cur_vec_t             adc_sample,
    output logic [qla_bus_pkg::DATA_W-1:0]     reg_rdata,
    output logic [qla_bus_pkg::NUM_AXES-1:0]   amp_disable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    // bus request as one bundle
    bus_req_t bus_req;

    // decoder to checkers
    axis_ctrl_t [NUM_AXES-1:0] axis_ctrl;
    logic [NUM_AXES-1:0]       amp_enable;

    // checkers to readback
    axis_status_t [NUM_AXES-1:0] axis_status;

    assign bus_req = '{addr: reg_addr, wdata: reg_wdata, wen: reg_wen};

    // ------------------------------------------------------------------------
    // bus write decode
    // ------------------------------------------------------------------------

    qla_reg_decode u_decode (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .bus        (bus_req),
        .axis_ctrl  (axis_ctrl),
        .amp_enable (amp_enable)
    );

    // ------------------------------------------------------------------------
    // per-axis checkers, each sees its own ADC slice
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        qla_axis_safety u_safety (
            .sysclk     (sysclk),
            .rst_n      (rst_n),
            .ctrl       (axis_ctrl[i]),
            .adc_valid  (adc_valid),
            .adc_sample (adc_sample[i]),
            .status     (axis_status[i])
        );
    end

    // reads use the same address as writes
    qla_readback u_readback (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .rd_addr     (bus_req.addr),
        .amp_enable  (amp_enable),
        .status      (axis_status),
        .reg_rdata   (reg_rdata),
        .amp_disable (amp_disable)
    );

endmodule

// File: logic/qla_bus_pkg.sv
// register bus package
// board/axis counts, bus widths, address field layout,
// device codes, board register address and the bus request struct

package qla_bus_pkg;

    // board dimensions
    localparam int NUM_AXES = 4;

    // bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // address split into channel (high nibble) and device (low nibble)
    localparam int CHAN_MSB = 7;
    localparam int CHAN_LSB = 4;
    localparam int DEV_MSB  = 3;
    localparam int DEV_LSB  = 0;

    // channel 0 is the board, axes start at channel 1
    localparam logic [CHAN_MSB-CHAN_LSB:0] CHAN_AXIS_BASE = 4'd1;

    // per-axis device codes
    localparam logic [DEV_MSB-DEV_LSB:0] DEV_ADC    = 4'd0;
    localparam logic [DEV_MSB-DEV_LSB:0] DEV_DAC    = 4'd1;
    localparam logic [DEV_MSB-DEV_LSB:0] DEV_STATUS = 4'd2;

    // amp enable mask lives in channel 0, device 0
    localparam logic [ADDR_W-1:0] BOARD_ENABLE_ADDR = 8'h00;

    // one bus request, write strobe is single cycle
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              wen;
    } bus_req_t;

endpackage

// File: logic/qla_readback.sv
// register readback
// registered read data mux over board and axis registers,
// registered amplifier disable vector

`timescale 1ns/1ps

module qla_readback (
    input  logic                                                   sysclk,
    input  logic                                                   rst_n,
    input  logic [qla_bus_pkg::ADDR_W-1:0]                         rd_addr,
    input  logic [qla_bus_pkg::NUM_AXES-1:0]                       amp_enable,
    input  qla_axis_pkg::axis_status_t [qla_bus_pkg::NUM_AXES-1:0] status,
    output logic [qla_bus_pkg::DATA_W-1:0]                         reg_rdata,
    output logic [qla_bus_pkg::NUM_AXES-1:0]                       amp_disable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    // address fields
    logic [CHAN_MSB-CHAN_LSB:0] chan;
    logic [DEV_MSB-DEV_LSB:0]   dev;

    // addressed axis, hit is low for channel 0 and channels past the axes
    axis_status_t sel;
    logic         hit;

    logic [DATA_W-1:0]   rdata_next;
    logic [NUM_AXES-1:0] fault_vec;

    assign chan = rd_addr[CHAN_MSB:CHAN_LSB];
    assign dev  = rd_addr[DEV_MSB:DEV_LSB];

    // ------------------------------------------------------------------------
    // read select
    // ------------------------------------------------------------------------

    always_comb begin
        sel = status[0];
        hit = 1'b0;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (chan == CHAN_AXIS_BASE + 4'(i)) begin
                sel = status[i];
                hit = 1'b1;
            end
        end
    end

    always_comb begin
        // unmapped reads return zero
        rdata_next = '0;
        if (rd_addr == BOARD_ENABLE_ADDR) begin
            // disable vector above the mask
            rdata_next[2*NUM_AXES-1:0] = {amp_disable, amp_enable};
        end else if (hit) begin
            case (dev)
                DEV_ADC:    rdata_next[CUR_W-1:0] = sel.fb;
                DEV_DAC:    rdata_next[CUR_W-1:0] = sel.cmd;
                DEV_STATUS: begin
                    rdata_next[DATA_W-1]       = sel.fault;
                    rdata_next[TRIP_CNT_W-1:0] = sel.trip_cnt;
                end
                default:    rdata_next = '0;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) reg_rdata <= '0;
        else        reg_rdata <= rdata_next;
    end

    // ------------------------------------------------------------------------
    // amplifier disables
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            fault_vec[i] = status[i].fault;
        end
    end

    // off unless enabled and healthy
    always_ff @(posedge sysclk) begin
        if (!rst_n) amp_disable <= '1;
        else        amp_disable <= ~amp_enable | fault_vec;
    end

    // amp lines go straight to the drivers, never let X out
    a_amp_known: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        !$isunknown(amp_disable)
    );

endmodule

// File: logic/qla_reg_decode.sv
// bus write decoder
// per-axis DAC command strobes and the board amp enable mask register

`timescale 1ns/1ps

module qla_reg_decode (
    input  logic                                                 sysclk,
    input  logic                                                 rst_n,
    input  qla_bus_pkg::bus_req_t                                bus,
    output qla_axis_pkg::axis_ctrl_t [qla_bus_pkg::NUM_AXES-1:0] axis_ctrl,
    output logic [qla_bus_pkg::NUM_AXES-1:0]                     amp_enable
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    // address fields
    logic [CHAN_MSB-CHAN_LSB:0] chan;
    logic [DEV_MSB-DEV_LSB:0]   dev;

    // command strobes gathered for the one-hot check
    logic [NUM_AXES-1:0] cmd_wen_vec;

    // board enable mask
    logic [NUM_AXES-1:0] mask_q;

    assign chan = bus.addr[CHAN_MSB:CHAN_LSB];
    assign dev  = bus.addr[DEV_MSB:DEV_LSB];

    // ------------------------------------------------------------------------
    // axis command strobes
    // ------------------------------------------------------------------------

    // combinational from the bus, only a DAC write to an axis channel
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            cmd_wen_vec[i] = bus.wen && (dev == DEV_DAC)
                             && (chan == CHAN_AXIS_BASE + 4'(i));
            axis_ctrl[i].cmd_wen = cmd_wen_vec[i];
            // low half of the write word is the current
            axis_ctrl[i].cmd = bus.wdata[CUR_W-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // board enable mask
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            // all amps off until software enables them
            mask_q <= '0;
        end else if (bus.wen && (bus.addr == BOARD_ENABLE_ADDR)) begin
            mask_q <= bus.wdata[NUM_AXES-1:0];
        end
    end

    assign amp_enable = mask_q;

    // one write, one axis
    a_cmd_onehot: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        $onehot0(cmd_wen_vec)
    );

endmodule

// File: testbench/qla_axis_stim.txt
# ops: W addr data | S adc0 adc1 adc2 adc3 | R addr expected_rdata
# A expected_amp_disable | E test_name   (all numbers hex)
R 00 000000f0
R 11 00008000
R 21 00008000
R 31 00008000
R 41 00008000
R 10 00008000
R 20 00008000
R 30 00008000
R 40 00008000
E reset_state
W 11 a5a58123
W 21 00007f00
W 31 ffff8400
W 41 12340123
R 11 00008123
R 21 00007f00
R 31 00008400
R 41 00000123
W 00 0000000f
A 0
R 00 0000000f
R 05 00000000
R 53 00000000
E cmd_and_mask
S 8010 8020 8030 8040
R 10 00008010
R 20 00008020
R 30 00008030
R 40 00008040
E feedback_capture
W 31 00008400
S 8010 8020 8901 8040
S 8010 8020 8901 8040
S 8010 8020 8901 8040
R 32 00000003
S 8010 8020 8901 8040
R 32 80000004
A 4
E over_current_trip
S 8010 7cff 8000 8040
S 8010 7cff 8000 8040
S 8010 7cff 8000 8040
R 22 00000003
S 8010 8300 8000 8040
R 22 00000000
R 32 80000000
E no_trip_on_break
W 31 00008200
R 32 00000000
A 0
E fault_clear

// File: testbench/qla_axis_tb.sv
// testbench for the current safety subsystem
// file-driven bus writes, ADC samples, readback and amp disable checks,
// per-test reporting and a watchdog

`timescale 1ns/1ps

module qla_axis_tb;

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    localparam string STIM_FILE = "testbench/qla_axis_stim.txt";

    logic                sysclk;
    logic                rst_n;
    logic [ADDR_W-1:0]   reg_addr;
    logic [DATA_W-1:0]   reg_wdata;
    logic                reg_wen;
    logic                adc_valid;
    cur_vec_t            adc_sample;
    logic [DATA_W-1:0]   reg_rdata;
    logic [NUM_AXES-1:0] amp_disable;

    // error counts, per test and overall
    int     test_errors  = 0;
    int     total_errors = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    longint wd_limit_ns  = 0;

    qla_axis_top u_dut (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .adc_valid   (adc_valid),
        .adc_sample  (adc_sample),
        .reg_rdata   (reg_rdata),
        .amp_disable (amp_disable)
    );

    // 100 ns period
    always #50 sysclk = ~sysclk;

    // ------------------------------------------------------------------------
    // bus and ADC drivers, all on the falling edge
    // ------------------------------------------------------------------------

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge sysclk);
        adc_valid = 1'b0;
        reg_addr  = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
    endtask

    task automatic adc_push(input cur_vec_t samples);
        @(negedge sysclk);
        reg_wen    = 1'b0;
        adc_sample = samples;
        adc_valid  = 1'b1;
    endtask

    // rdata is registered, so compare one edge after the address goes out
    task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        @(negedge sysclk);
        reg_wen   = 1'b0;
        adc_valid = 1'b0;
        reg_addr  = addr;
        @(posedge sysclk);
        @(negedge sysclk);
        if (reg_rdata !== exp) begin
            $display("Error at %0t: reg_rdata (addr %h) expected %h got %h",
                     $time, addr, exp, reg_rdata);
            test_errors++;
        end
    endtask

    // amp_disable lags mask and fault by one edge
    task automatic disable_check(input logic [NUM_AXES-1:0] exp);
        @(negedge sysclk);
        reg_wen   = 1'b0;
        adc_valid = 1'b0;
        @(posedge sysclk);
        @(negedge sysclk);
        if (amp_disable !== exp) begin
            $display("Error at %0t: amp_disable expected %b got %b", $time, exp, amp_disable);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        int          fd;
        int          rc;
        int          n_lines;
        string       op;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [15:0] c0;
        logic [15:0] c1;
        logic [15:0] c2;
        logic [15:0] c3;

        sysclk     = 1'b0;
        rst_n      = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        reg_wen    = 1'b0;
        adc_valid  = 1'b0;
        adc_sample = {NUM_AXES{CUR_MID}};
        n_lines    = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("tests failed");
            $finish;
        end else begin
            // line count sizes the watchdog
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) n_lines++;
            end
            $fclose(fd);
            wd_limit_ns = (n_lines + 20) * 100 * 4;
            fd = $fopen(STIM_FILE, "r");

            repeat (8) @(negedge sysclk);
            rst_n = 1'b1;

            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    rc = $fgets(line, fd);
                end else if (op == "W") begin
                    rc = $fscanf(fd, "%h %h", a, d);
                    bus_write(a[ADDR_W-1:0], d);
                end else if (op == "S") begin
                    rc = $fscanf(fd, "%h %h %h %h", c0, c1, c2, c3);
                    // axis 0 in the low slice
                    adc_push({c3, c2, c1, c0});
                end else if (op == "R") begin
                    rc = $fscanf(fd, "%h %h", a, d);
                    read_check(a[ADDR_W-1:0], d);
                end else if (op == "A") begin
                    rc = $fscanf(fd, "%h", d);
                    disable_check(d[NUM_AXES-1:0]);
                end else if (op == "E") begin
                    rc = $fscanf(fd, "%s", line);
                    finish_test(line);
                end else begin
                    $display("unknown stimulus op %s in the stimulus file", op);
                    test_errors++;
                    rc = $fgets(line, fd);
                end
            end
            $fclose(fd);

            @(negedge sysclk);
            reg_wen   = 1'b0;
            adc_valid = 1'b0;
            // errors after the last end marker still count
            total_errors += test_errors;
            $display("summary: %0d tests run, %0d passing, %0d failing, %0d check errors",
                     tests_run, tests_run - tests_failed, tests_failed, total_errors);
            if (total_errors == 0 && tests_run > 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

    // watchdog, armed once the stimulus length is known
    initial begin
        wait (wd_limit_ns > 0);
        #(wd_limit_ns);
        $display("watchdog expired after %0d ns, the run timed out", wd_limit_ns);
        $display("tests failed");
        $finish;
    end

endmodule

// File: vlog.f
logic/qla_bus_pkg.sv
logic/qla_axis_pkg.sv
logic/qla_reg_decode.sv
logic/qla_axis_safety.sv
logic/qla_readback.sv
logic/qla_axis_top.sv
testbench/qla_axis_tb.sv
